// File: hw/exec_pkg.sv
// Shared types for the add/sub execute cluster
// Opcodes, branch kinds, issue and CDB packets

package exec_pkg;

	localparam int TAG_W = 4; // ROB tag width
	localparam int XLEN  = 32;

	// Bit 2 set on every code that subtracts
	typedef enum logic [3:0] {
		ADD  = 4'b0000,
		XOR  = 4'b0001,
		OR   = 4'b0010,
		AND  = 4'b0011,
		SUB  = 4'b0100,
		SLT  = 4'b0101,
		SLTU = 4'b0110
	} alu_op_t;

	typedef enum logic [2:0] {
		BR_NONE = 3'd0,
		BEQ     = 3'd1,
		BNE     = 3'd2,
		BLT     = 3'd3,
		BGE     = 3'd4,
		BLTU    = 3'd5,
		BGEU    = 3'd6
	} branch_t;

	typedef struct packed {
		logic [XLEN-1:0]  result;
		logic [TAG_W-1:0] dest_tag;
		logic             branch_taken;
		logic             is_load; // Address calc for a load
	} cdb_packet_t;

	typedef struct packed {
		alu_op_t          op;
		branch_t          br;
		logic             is_load;
		logic [TAG_W-1:0] tag;
		logic [XLEN-1:0]  rs1;
		logic [XLEN-1:0]  rs2;
	} issue_t;

endpackage

// File: hw/adder_32bit.sv
// Ripple-carry adder/subtractor
// Produces the sum and the zero, negative, overflow and carry flags

module adder_32bit (
	input  logic [exec_pkg::XLEN-1:0] a,
	input  logic [exec_pkg::XLEN-1:0] b,
	input  logic                      sub,
	output logic [exec_pkg::XLEN-1:0] sum,
	output logic                      zero,
	output logic                      negative,
	output logic                      overflow,
	output logic                      carry
);

	logic [exec_pkg::XLEN:0]   c_chain;
	logic [exec_pkg::XLEN-1:0] b_eff;

	// Two's complement subtract: invert b, carry in of one
	assign b_eff      = sub ? ~b : b;
	assign c_chain[0] = sub;

	genvar i;
	generate
		for (i = 0; i < exec_pkg::XLEN; i++) begin : g_bit
			assign sum[i]       = a[i] ^ b_eff[i] ^ c_chain[i];
			assign c_chain[i+1] = (a[i] & b_eff[i]) | (c_chain[i] & (a[i] ^ b_eff[i]));
		end
	endgenerate

	// Raw carry out, so a borrow reads as carry low
	assign carry    = c_chain[exec_pkg::XLEN];
	assign overflow = c_chain[exec_pkg::XLEN] ^ c_chain[exec_pkg::XLEN-1];
	assign zero     = (sum == '0);
	assign negative = sum[exec_pkg::XLEN-1];

endmodule

// File: hw/add_unit.sv
// Add/sub functional unit
// Computes the ALU result or branch outcome and holds one CDB packet
// until the arbiter takes it

module add_unit (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  issue_valid,
	input  exec_pkg::issue_t      issue_op,
	input  logic                  yumi,
	output logic                  ready,
	output logic                  done,
	output exec_pkg::cdb_packet_t pkt
);

	logic [exec_pkg::XLEN-1:0] sum;
	logic [exec_pkg::XLEN-1:0] result;
	logic zero, negative, overflow, carry;
	logic is_branch;
	logic do_sub;
	logic signed_lt;
	logic br_taken;
	logic capture;

	assign is_branch = (issue_op.br != exec_pkg::BR_NONE);
	assign do_sub    = issue_op.op[2] | is_branch; // Branches always compare by subtraction
	assign signed_lt = negative ^ overflow;

	adder_32bit u_adder (
		.a        (issue_op.rs1),
		.b        (issue_op.rs2),
		.sub      (do_sub),
		.sum      (sum),
		.zero     (zero),
		.negative (negative),
		.overflow (overflow),
		.carry    (carry)
	);

	always_comb begin
		case (issue_op.br)
			exec_pkg::BEQ:  br_taken = zero;
			exec_pkg::BNE:  br_taken = ~zero;
			exec_pkg::BLT:  br_taken = signed_lt;
			exec_pkg::BGE:  br_taken = ~signed_lt;
			exec_pkg::BLTU: br_taken = ~carry; // Borrow out
			exec_pkg::BGEU: br_taken = carry;
			default:        br_taken = 1'b0;
		endcase
	end

	always_comb begin
		if (is_branch) begin
			result = sum; // Difference goes out with the branch
		end else begin
			case (issue_op.op)
				exec_pkg::SLT:  result = {{(exec_pkg::XLEN-1){1'b0}}, signed_lt};
				exec_pkg::SLTU: result = {{(exec_pkg::XLEN-1){1'b0}}, ~carry};
				exec_pkg::XOR:  result = issue_op.rs1 ^ issue_op.rs2;
				exec_pkg::OR:   result = issue_op.rs1 | issue_op.rs2;
				exec_pkg::AND:  result = issue_op.rs1 & issue_op.rs2;
				default:        result = sum; // ADD, SUB
			endcase
		end
	end

	// One item deep, busy while a result waits for the CDB
	assign ready   = ~done;
	assign capture = issue_valid & ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			done <= 1'b0;
		end else if (capture) begin
			done <= 1'b1;
		end else if (yumi) begin
			done <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			pkt.result       <= result;
			pkt.dest_tag     <= issue_op.tag;
			pkt.branch_taken <= is_branch & br_taken;
			pkt.is_load      <= issue_op.is_load;
		end else if (yumi) begin
			pkt <= '0;
		end
	end

	// Packet must stay put while it waits for a grant
	a_done_held: assert property (@(posedge clk) disable iff (!rst_n)
		done && !yumi |=> done && $stable(pkt));

	// Queue only offers work to a free unit
	a_issue_ready: assert property (@(posedge clk) disable iff (!rst_n)
		issue_valid |-> ready);

endmodule

// File: hw/rs_queue.sv
// In-order reservation queue
// Buffers dispatched operations and issues the head to a free unit,
// unit 0 first

module rs_queue #(
	parameter int RS_DEPTH = 4
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             dispatch_valid,
	input  exec_pkg::issue_t dispatch_op,
	output logic             dispatch_ready,
	input  logic             ready_0,
	input  logic             ready_1,
	output logic             issue_valid_0,
	output logic             issue_valid_1,
	output exec_pkg::issue_t issue_op
);

	localparam int PTR_W = $clog2(RS_DEPTH);

	exec_pkg::issue_t mem [RS_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic full, empty;
	logic push, pop;

	assign full  = (count == RS_DEPTH[PTR_W:0]);
	assign empty = (count == '0);

	assign dispatch_ready = ~full;
	assign push           = dispatch_valid & dispatch_ready;

	// Head visible as soon as it is stored
	assign issue_op      = mem[rd_ptr];
	assign issue_valid_0 = ~empty & ready_0;
	assign issue_valid_1 = ~empty & ~ready_0 & ready_1; // Only if unit 0 is busy
	assign pop           = issue_valid_0 | issue_valid_1;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1; // Wraps, depth is a power of two
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= dispatch_op;
		end
	end

	// No push when full, so occupancy never passes the depth
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		count <= RS_DEPTH[PTR_W:0]);

	a_one_issue: assert property (@(posedge clk) disable iff (!rst_n)
		!(issue_valid_0 && issue_valid_1));

endmodule

// File: hw/cdb_arbiter.sv
// Round-robin CDB arbiter for two units
// Grants one finished unit per cycle and registers its packet on the CDB

module cdb_arbiter (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  done_0,
	input  logic                  done_1,
	input  exec_pkg::cdb_packet_t pkt_0,
	input  exec_pkg::cdb_packet_t pkt_1,
	output logic                  grant_0,
	output logic                  grant_1,
	output logic                  cdb_valid,
	output exec_pkg::cdb_packet_t cdb_pkt
);

	logic last_winner; // High when unit 1 won last

	// On a tie the unit that did not win last goes first
	assign grant_0 = done_0 & (~done_1 | last_winner);
	assign grant_1 = done_1 & (~done_0 | ~last_winner);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			last_winner <= 1'b0;
			cdb_valid   <= 1'b0;
		end else begin
			cdb_valid <= grant_0 | grant_1;
			if (grant_0 | grant_1) begin
				last_winner <= grant_1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (grant_1) begin
			cdb_pkt <= pkt_1;
		end else if (grant_0) begin
			cdb_pkt <= pkt_0;
		end
	end

	a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
		!(grant_0 && grant_1));

endmodule

// File: hw/add_cluster.sv
// Add/sub execute cluster
// Reservation queue feeding two add/sub units that share one CDB

module add_cluster #(
	parameter int RS_DEPTH = 4
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  dispatch_valid,
	input  exec_pkg::issue_t      dispatch_op,
	output logic                  dispatch_ready,
	output logic                  cdb_valid,
	output exec_pkg::cdb_packet_t cdb_pkt
);

	exec_pkg::issue_t      issue_op; // Shared by both units
	exec_pkg::cdb_packet_t pkt_0;
	exec_pkg::cdb_packet_t pkt_1;
	logic issue_valid_0, issue_valid_1;
	logic ready_0, ready_1;
	logic done_0, done_1;
	logic grant_0, grant_1;

	rs_queue #(
		.RS_DEPTH (RS_DEPTH)
	) u_queue (
		.clk            (clk),
		.rst_n          (rst_n),
		.dispatch_valid (dispatch_valid),
		.dispatch_op    (dispatch_op),
		.dispatch_ready (dispatch_ready),
		.ready_0        (ready_0),
		.ready_1        (ready_1),
		.issue_valid_0  (issue_valid_0),
		.issue_valid_1  (issue_valid_1),
		.issue_op       (issue_op)
	);

	add_unit u_unit_0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.issue_valid (issue_valid_0),
		.issue_op    (issue_op),
		.yumi        (grant_0),
		.ready       (ready_0),
		.done        (done_0),
		.pkt         (pkt_0)
	);

	add_unit u_unit_1 (
		.clk         (clk),
		.rst_n       (rst_n),
		.issue_valid (issue_valid_1),
		.issue_op    (issue_op),
		.yumi        (grant_1),
		.ready       (ready_1),
		.done        (done_1),
		.pkt         (pkt_1)
	);

	cdb_arbiter u_arb (
		.clk       (clk),
		.rst_n     (rst_n),
		.done_0    (done_0),
		.done_1    (done_1),
		.pkt_0     (pkt_0),
		.pkt_1     (pkt_1),
		.grant_0   (grant_0),
		.grant_1   (grant_1),
		.cdb_valid (cdb_valid),
		.cdb_pkt   (cdb_pkt)
	);

endmodule

// File: test/tb_add_cluster.sv
// Testbench for the add/sub execute cluster
// Directed tests, reference model and a scoreboard indexed by ROB tag

module tb_add_cluster;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_OPS        = 103; // Operations dispatched over all tests
	localparam int RESET_CYCLES = 5;
	localparam int N_TAGS       = 2 ** exec_pkg::TAG_W;

	logic clk, rst_n, dispatch_valid, dispatch_ready, cdb_valid;
	exec_pkg::issue_t      dispatch_op;
	exec_pkg::cdb_packet_t cdb_pkt;
	exec_pkg::cdb_packet_t expected [N_TAGS];
	logic [N_TAGS-1:0]        pending; // Tags still waiting for the CDB
	logic [exec_pkg::TAG_W-1:0] next_tag;
	logic [31:0] rng;
	int n_pending, errors, err_mark, tests_passed, tests_failed;
	string cur_test;

	add_cluster #(.RS_DEPTH(4)) dut0 (
		.clk            (clk),
		.rst_n          (rst_n),
		.dispatch_valid (dispatch_valid),
		.dispatch_op    (dispatch_op),
		.dispatch_ready (dispatch_ready),
		.cdb_valid      (cdb_valid),
		.cdb_pkt        (cdb_pkt)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		#((N_OPS * 200 + RESET_CYCLES) * 10);
		$display("Watchdog expired with %0d operations outstanding", n_pending);
		$display("Test failed");
		$finish;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Expected CDB packet straight from the ISA meaning of each op
	function automatic exec_pkg::cdb_packet_t model(input exec_pkg::issue_t op);
		exec_pkg::cdb_packet_t p;
		logic lt_s, lt_u;
		lt_s           = $signed(op.rs1) < $signed(op.rs2);
		lt_u           = op.rs1 < op.rs2;
		p.dest_tag     = op.tag;
		p.is_load      = op.is_load;
		p.branch_taken = 1'b0;
		p.result       = op.rs1 - op.rs2; // Branches report the difference
		case (op.br)
			exec_pkg::BEQ:  p.branch_taken = (op.rs1 == op.rs2);
			exec_pkg::BNE:  p.branch_taken = (op.rs1 != op.rs2);
			exec_pkg::BLT:  p.branch_taken = lt_s;
			exec_pkg::BGE:  p.branch_taken = ~lt_s;
			exec_pkg::BLTU: p.branch_taken = lt_u;
			exec_pkg::BGEU: p.branch_taken = ~lt_u;
			default: begin
				case (op.op)
					exec_pkg::ADD:  p.result = op.rs1 + op.rs2;
					exec_pkg::SLT:  p.result = {31'b0, lt_s};
					exec_pkg::SLTU: p.result = {31'b0, lt_u};
					exec_pkg::XOR:  p.result = op.rs1 ^ op.rs2;
					exec_pkg::OR:   p.result = op.rs1 | op.rs2;
					exec_pkg::AND:  p.result = op.rs1 & op.rs2;
					default:        p.result = op.rs1 - op.rs2;
				endcase
			end
		endcase
		return p;
	endfunction

	task automatic compare_packet(input exec_pkg::cdb_packet_t exp,
			input exec_pkg::cdb_packet_t act);
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s: expected %h, actual %h", cur_test, exp, act);
		end
	endtask

	task automatic compare_bit(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("MISMATCH %s %s: expected %b, actual %b", cur_test, what, exp, act);
		end
	endtask

	// CDB monitor, retires each tag against the scoreboard
	always @(negedge clk) begin
		if (rst_n && cdb_valid) begin
			if (!pending[cdb_pkt.dest_tag]) begin
				errors++;
				$display("Error in %s: CDB carried tag %0d with no operation in flight",
					cur_test, cdb_pkt.dest_tag);
			end else begin
				compare_packet(expected[cdb_pkt.dest_tag], cdb_pkt);
				compare_bit("branch_taken", expected[cdb_pkt.dest_tag].branch_taken,
					cdb_pkt.branch_taken);
				pending[cdb_pkt.dest_tag] = 1'b0;
				n_pending--;
			end
		end
	end

	task automatic send_op(input exec_pkg::alu_op_t op, input exec_pkg::branch_t br,
			input logic ld, input logic [31:0] a, input logic [31:0] b);
		exec_pkg::issue_t it;
		logic accepted;
		it       = '{op: op, br: br, is_load: ld, tag: next_tag, rs1: a, rs2: b};
		next_tag = next_tag + 1'b1;
		if (pending[it.tag]) begin
			dispatch_valid <= 1'b0; // Tag still in use, wait for it to retire
			while (pending[it.tag]) begin
				@(posedge clk);
			end
		end
		expected[it.tag] = model(it);
		pending[it.tag]  = 1'b1;
		n_pending++;
		dispatch_valid <= 1'b1;
		dispatch_op    <= it;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge clk);
			accepted = dispatch_ready;
			@(posedge clk);
		end
	endtask

	task automatic drain_all();
		int waited;
		waited = 0;
		dispatch_valid <= 1'b0;
		while (n_pending != 0 && waited < 100) begin
			@(posedge clk);
			waited++;
		end
		if (n_pending != 0) begin
			errors++;
			$display("Error in %s: %0d operations never came back on the CDB",
				cur_test, n_pending);
			pending   = '0;
			n_pending = 0;
		end
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		err_mark = errors;
	endtask

	task automatic end_test();
		if (errors == err_mark) begin
			tests_passed++;
			$display("PASS %s", cur_test);
		end else begin
			tests_failed++;
			$display("FAIL %s: %0d checks failed", cur_test, errors - err_mark);
		end
	endtask

	task automatic test_reset_state();
		begin_test("reset_state");
		@(negedge clk);
		compare_bit("dispatch_ready", 1'b1, dispatch_ready);
		compare_bit("cdb_valid", 1'b0, cdb_valid);
		@(posedge clk);
		end_test();
	endtask

	// Every opcode with random and corner operands
	task automatic test_alu_ops();
		logic [31:0] ra, rb;
		begin_test("alu_ops");
		for (int i = 0; i < 7; i++) begin
			for (int k = 0; k < 5; k++) begin
				rng = xorshift32(rng);
				ra  = rng;
				rng = xorshift32(rng);
				rb  = rng;
				case (k)
					1: begin
						ra = 32'h0;
						rb = 32'hffff_ffff;
					end
					2: begin
						ra = 32'h8000_0000;
						rb = 32'h1;
					end
					3: begin
						ra = 32'hffff_ffff;
						rb = 32'h8000_0000;
					end
					4: rb = ra; // Equal operands
					default: ;
				endcase
				send_op(exec_pkg::alu_op_t'(i), exec_pkg::BR_NONE, 1'b0, ra, rb);
			end
		end
		drain_all();
		end_test();
	endtask

	task automatic test_branches();
		logic [31:0] a_vals [4];
		logic [31:0] b_vals [4];
		rng = xorshift32(rng);
		a_vals = '{rng, 32'hffff_fff0, 32'h3, 32'h8000_0000};
		b_vals = '{rng, 32'hffff_fffe, 32'h4000_0000, 32'h7fff_ffff};
		begin_test("branches");
		for (int i = 1; i < 7; i++) begin
			for (int k = 0; k < 4; k++) begin
				// ADD opcode, so the branch itself must force the subtract
				send_op(exec_pkg::ADD, exec_pkg::branch_t'(i), 1'b0, a_vals[k], b_vals[k]);
				send_op(exec_pkg::ADD, exec_pkg::branch_t'(i), 1'b0, b_vals[k], a_vals[k]);
			end
		end
		drain_all();
		end_test();
	endtask

	task automatic test_load_tags();
		begin_test("load_tags");
		for (int k = 0; k < 8; k++) begin
			rng = xorshift32(rng);
			send_op(k[1] ? exec_pkg::SUB : exec_pkg::ADD, exec_pkg::BR_NONE, k[0],
				rng, {rng[15:0], rng[31:16]});
		end
		drain_all();
		end_test();
	endtask

	// Two alternating units absorb one op per cycle, so the queue stays shallow
	task automatic test_burst();
		begin_test("burst");
		for (int k = 0; k < 12; k++) begin
			rng = xorshift32(rng);
			send_op(exec_pkg::alu_op_t'(rng % 7), exec_pkg::BR_NONE, rng[8],
				rng, xorshift32(rng));
		end
		drain_all();
		@(negedge clk);
		compare_bit("dispatch_ready after drain", 1'b1, dispatch_ready);
		compare_bit("cdb_valid after drain", 1'b0, cdb_valid);
		@(posedge clk);
		end_test();
	endtask

	initial begin
		rst_n          = 1'b0;
		dispatch_valid = 1'b0;
		dispatch_op    = '0;
		pending        = '0;
		n_pending      = 0;
		errors         = 0;
		tests_passed   = 0;
		tests_failed   = 0;
		next_tag       = '0;
		rng            = 32'h3e7f38d0;
		cur_test       = "reset";
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		test_reset_state();
		test_alu_ops();
		test_branches();
		test_load_tags();
		test_burst();
		$display("%0d tests passed, %0d tests failed, %0d errors",
			tests_passed, tests_failed, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: build.f
hw/exec_pkg.sv
hw/adder_32bit.sv
hw/add_unit.sv
hw/rs_queue.sv
hw/cdb_arbiter.sv
hw/add_cluster.sv
test/tb_add_cluster.sv
